/* hdl/vga_config.svh */
// VGA 640x480 horizontal and vertical timing widths and colour depth macros
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// horizontal timing, all values in pixels
// the line is display, then front porch, then sync pulse, then back porch
`define VGA_HD 640
`define VGA_HF 16
`define VGA_HB 48
`define VGA_HR 96

// vertical timing, all values in lines
// the frame uses the same ordering as the line
`define VGA_VD 480
`define VGA_VF 10
`define VGA_VB 33
`define VGA_VR 2

// bits per colour channel, so a pixel carries three of these
`define VGA_CW 4

`endif

/* hdl/vga_pkg.sv */
// VGA position, sync, colour and mode struct types, pattern enumeration and reset mode
`include "vga_config.svh"

package vga_pkg;

	// pixel position as seen by the counters
	// active is high only inside the 640x480 display area
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active;
	} pix_pos_t;

	// both sync lines are active low, so 1 means idle
	typedef struct packed {
		logic hsync;
		logic vsync;
	} sync_t;

	// one colour, channel order matches the VGA connector
	typedef struct packed {
		logic [`VGA_CW-1:0] r;
		logic [`VGA_CW-1:0] g;
		logic [`VGA_CW-1:0] b;
	} rgb_t;

	// test patterns the pattern generator knows how to draw
	typedef enum logic [1:0] {
		PAT_SOLID    = 2'd0,
		PAT_BARS     = 2'd1,
		PAT_CHECKER  = 2'd2,
		PAT_GRADIENT = 2'd3
	} pattern_e;

	// display mode written by the host
	// cell_log2 picks the checker cell size as a power of two
	typedef struct packed {
		pattern_e   pattern;
		rgb_t       color;
		logic [2:0] cell_log2;
	} mode_cfg_t;

	// mode in force after reset, colour bars with a white base colour
	localparam mode_cfg_t MODE_RESET = '{
		pattern:   PAT_BARS,
		color:     '{r: {`VGA_CW{1'b1}}, g: {`VGA_CW{1'b1}}, b: {`VGA_CW{1'b1}}},
		cell_log2: 3'd5
	};

endpackage

/* hdl/vga_timing.sv */
// VGA pixel enable divider, column and row counters and registered sync generator
`include "vga_config.svh"

module vga_timing
	import vga_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	output logic     pix_en,
	output pix_pos_t pos,
	output sync_t    sync,
	output logic     frame_end
);

	// line and frame totals, 800 pixels by 525 lines
	localparam int H_TOTAL = `VGA_HD + `VGA_HF + `VGA_HB + `VGA_HR;
	localparam int V_TOTAL = `VGA_VD + `VGA_VF + `VGA_VB + `VGA_VR;

	// the pulse begins right after display plus front porch
	localparam int H_PULSE_START = `VGA_HD + `VGA_HF;
	localparam int H_PULSE_END   = H_PULSE_START + `VGA_HR - 1;
	localparam int V_PULSE_START = `VGA_VD + `VGA_VF;
	localparam int V_PULSE_END   = V_PULSE_START + `VGA_VR - 1;

	logic [9:0] hcnt;
	logic [9:0] vcnt;
	logic       h_end;
	logic       v_end;
	logic       h_pulse;
	logic       v_pulse;

	// the enable toggles every clock, which halves 50 MHz into a 25 MHz pixel rate
	// it is low in reset and rises on the first cycle afterwards
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			pix_en <= 1'b0;
		else
			pix_en <= ~pix_en;
	end

	// last column of a line and last line of a frame
	assign h_end = (hcnt == 10'(H_TOTAL - 1));
	assign v_end = (vcnt == 10'(V_TOTAL - 1));

	// column counter steps every tick, the row counter steps when a line wraps
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (pix_en)
		begin
			if (h_end)
			begin
				hcnt <= '0;
				if (v_end)
					vcnt <= '0;
				else
					vcnt <= vcnt + 10'd1;
			end
			else
			begin
				hcnt <= hcnt + 10'd1;
			end
		end
	end

	// pulse windows, inclusive at both ends
	assign h_pulse = (hcnt >= 10'(H_PULSE_START)) && (hcnt <= 10'(H_PULSE_END));
	assign v_pulse = (vcnt >= 10'(V_PULSE_START)) && (vcnt <= 10'(V_PULSE_END));

	// sync is registered, so it shows position p one tick after pos does
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sync.hsync <= 1'b1;
			sync.vsync <= 1'b1;
		end
		else if (pix_en)
		begin
			sync.hsync <= ~h_pulse;
			sync.vsync <= ~v_pulse;
		end
	end

	assign pos.x      = hcnt;
	assign pos.y      = vcnt;
	assign pos.active = (hcnt < 10'(`VGA_HD)) && (vcnt < 10'(`VGA_VD));

	// one pulse per frame, on the tick that leaves the bottom right corner
	assign frame_end = pix_en && h_end && v_end;

	// the column counter stays inside the line total
	a_hcnt_range: assert property (@(posedge clk) disable iff (rst)
		hcnt < 10'(H_TOTAL));

endmodule

/* hdl/mode_regs.sv */
// VGA host mode write port with pending register applied at the frame boundary
module mode_regs
	import vga_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      frame_end,
	input  logic      cfg_valid,
	input  mode_cfg_t cfg_data,
	output logic      cfg_ready,
	output mode_cfg_t mode
);

	logic      pend_valid;
	mode_cfg_t pend_data;
	logic      fire;

	// only one write can wait at a time, so the port is ready whenever the slot is empty
	assign cfg_ready = ~pend_valid;
	assign fire      = cfg_valid & cfg_ready;

	// pending flag and the active mode
	// a frame boundary moves any waiting write into the active mode
	// a write that lands on the boundary cycle itself still belongs to the old frame
	// so it goes straight to the active mode and skips the pending slot
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pend_valid <= 1'b0;
			mode       <= MODE_RESET;
		end
		else if (frame_end)
		begin
			pend_valid <= 1'b0;
			if (pend_valid)
				mode <= pend_data;
			else if (fire)
				mode <= cfg_data;
		end
		else if (fire)
		begin
			pend_valid <= 1'b1;
		end
	end

	// the waiting value itself, loaded on every accepted write
	always_ff @(posedge clk)
	begin
		if (fire)
			pend_data <= cfg_data;
	end

	// while the host is held off it must keep offering the same mode
	a_cfg_stable: assert property (@(posedge clk) disable iff (rst)
		(cfg_valid && !cfg_ready) |=> (!cfg_valid || $stable(cfg_data)));

endmodule

/* hdl/pattern_gen.sv */
// VGA two-stage pattern pipeline mapping pixel position and mode to colour
`include "vga_config.svh"

module pattern_gen
	import vga_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      pix_en,
	input  pix_pos_t  pos,
	input  mode_cfg_t mode,
	output rgb_t      rgb,
	output logic      rgb_active
);

	// eight bars share the visible width, 80 pixels each
	localparam int BAR_W = `VGA_HD / 8;

	// everything stage 2 needs, with the mode captured next to the pixel
	typedef struct packed {
		logic [2:0] bar;
		logic       parity;
		rgb_t       grad;
		pattern_e   pattern;
		rgb_t       color;
	} stage1_t;

	stage1_t    s1_next;
	stage1_t    s1;
	logic       s1_active;
	logic [9:0] bar_full;
	rgb_t       rgb_next;

	// stage 1 decode of the raw position
	// blanked columns give bar indices above 7, which are never shown
	assign bar_full = pos.x / 10'(BAR_W);

	always_comb
	begin
		s1_next.bar     = bar_full[2:0];
		s1_next.parity  = pos.x[mode.cell_log2] ^ pos.y[mode.cell_log2];
		s1_next.grad.r  = pos.x[9 -: `VGA_CW];
		s1_next.grad.g  = pos.y[8 -: `VGA_CW];
		s1_next.grad.b  = pos.x[9 -: `VGA_CW] ^ pos.y[8 -: `VGA_CW];
		s1_next.pattern = mode.pattern;
		s1_next.color   = mode.color;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			s1_active <= 1'b0;
		else if (pix_en)
			s1_active <= pos.active;
	end

	always_ff @(posedge clk)
	begin
		if (pix_en)
			s1 <= s1_next;
	end

	// stage 2 picks the colour for the pattern that travelled with this pixel
	always_comb
	begin
		case (s1.pattern)
			PAT_SOLID:
				rgb_next = s1.color;
			PAT_BARS:
			begin
				// bar index bits map straight onto the three channels
				rgb_next.r = {`VGA_CW{s1.bar[2]}};
				rgb_next.g = {`VGA_CW{s1.bar[1]}};
				rgb_next.b = {`VGA_CW{s1.bar[0]}};
			end
			PAT_CHECKER:
				rgb_next = s1.parity ? rgb_t'(~s1.color) : s1.color;
			default:
				rgb_next = s1.grad;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			rgb_active <= 1'b0;
		else if (pix_en)
			rgb_active <= s1_active;
	end

	always_ff @(posedge clk)
	begin
		if (pix_en)
			rgb <= rgb_next;
	end

endmodule

/* hdl/vga_out.sv */
// VGA sync alignment delay, colour blanking and registered output pins
module vga_out
	import vga_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  pix_en,
	input  sync_t sync,
	input  rgb_t  rgb,
	input  logic  rgb_active,
	output logic  hsync,
	output logic  vsync,
	output rgb_t  vga_rgb
);

	// sync arrives one tick after position, colour two ticks after
	// this single stage brings sync level with colour
	sync_t sync_d;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sync_d.hsync <= 1'b1;
			sync_d.vsync <= 1'b1;
		end
		else if (pix_en)
		begin
			sync_d <= sync;
		end
	end

	// pin registers, colour is forced to black outside the visible area
	// the monitor uses the blanked porches as its black reference
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			vga_rgb <= '0;
		end
		else if (pix_en)
		begin
			hsync   <= sync_d.hsync;
			vsync   <= sync_d.vsync;
			vga_rgb <= rgb_active ? rgb : '0;
		end
	end

	// vertical sync only falls in blanked lines, so colour must be black then
	a_blank_vsync: assert property (@(posedge clk) disable iff (rst)
		!vsync |-> (vga_rgb == '0));

endmodule

/* hdl/vga_top.sv */
// VGA display top level joining timing, mode register, pattern generator and output stage
module vga_top
	import vga_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      cfg_valid,
	input  mode_cfg_t cfg_data,
	output logic      cfg_ready,
	output logic      hsync,
	output logic      vsync,
	output rgb_t      rgb,
	output logic      pix_en
);

	pix_pos_t  pos;
	sync_t     sync;
	logic      frame_end;
	mode_cfg_t mode;
	rgb_t      pat_rgb;
	logic      pat_active;

	// counters and raw sync, the pixel enable also goes out to the pins
	vga_timing u_timing (
		.clk       (clk),
		.rst       (rst),
		.pix_en    (pix_en),
		.pos       (pos),
		.sync      (sync),
		.frame_end (frame_end)
	);

	// host writes land here and switch over between frames
	mode_regs u_mode (
		.clk       (clk),
		.rst       (rst),
		.frame_end (frame_end),
		.cfg_valid (cfg_valid),
		.cfg_data  (cfg_data),
		.cfg_ready (cfg_ready),
		.mode      (mode)
	);

	// colour lags the position by two ticks
	pattern_gen u_pattern (
		.clk        (clk),
		.rst        (rst),
		.pix_en     (pix_en),
		.pos        (pos),
		.mode       (mode),
		.rgb        (pat_rgb),
		.rgb_active (pat_active)
	);

	// pins show position p three ticks after the counters
	vga_out u_out (
		.clk        (clk),
		.rst        (rst),
		.pix_en     (pix_en),
		.sync       (sync),
		.rgb        (pat_rgb),
		.rgb_active (pat_active),
		.hsync      (hsync),
		.vsync      (vsync),
		.vga_rgb    (rgb)
	);

endmodule

/* sim/vga_tb.sv */
// VGA testbench with clock, reset, LFSR, host mode writes, reference model, compare and watchdog
`include "vga_config.svh"

module vga_tb
	import vga_pkg::*;
();

	localparam int H_TOTAL     = `VGA_HD + `VGA_HF + `VGA_HB + `VGA_HR;
	localparam int V_TOTAL     = `VGA_VD + `VGA_VF + `VGA_VB + `VGA_VR;
	localparam int FRAME_TICKS = H_TOTAL * V_TOTAL;
	// pins lag the counters by three ticks, so the last pixel shows three ticks late
	localparam int END_TICKS   = 5 * FRAME_TICKS + 3;
	localparam longint WATCHDOG = (longint'(5) * FRAME_TICKS * 2 + 4000) * 10;

	// mode after reset, colour bars on a white base with 32-pixel checker cells
	localparam mode_cfg_t BOOT_MODE = '{
		pattern:   PAT_BARS,
		color:     12'hfff,
		cell_log2: 3'd5
	};

	// what the pins carry for one pixel
	typedef struct packed {
		logic hsync;
		logic vsync;
		rgb_t rgb;
	} pins_t;

	logic      clk;
	logic      rst;
	logic      cfg_valid;
	mode_cfg_t cfg_data;
	logic      cfg_ready;
	logic      hsync;
	logic      vsync;
	rgb_t      rgb;
	logic      pix_en;

	logic [31:0] lfsr;
	int          n_ticks;
	int          hlow;
	int          vlow;
	int          accept_frame;
	bit          reset_seen;
	logic        pix_en_last;
	mode_cfg_t   mode_at [0:7];

	vga_top UUT (
		.clk       (clk),
		.rst       (rst),
		.cfg_valid (cfg_valid),
		.cfg_data  (cfg_data),
		.cfg_ready (cfg_ready),
		.hsync     (hsync),
		.vsync     (vsync),
		.rgb       (rgb),
		.pix_en    (pix_en)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// expected pins for one position, worked out from the display timing and pattern rules
	function automatic pins_t ref_pins(input int x, input int y, input mode_cfg_t m);
		pins_t      e;
		logic [9:0] xv;
		logic [9:0] yv;
		logic [2:0] bar;
		logic       parity;
		xv      = 10'(x);
		yv      = 10'(y);
		e.hsync = !((x >= `VGA_HD + `VGA_HF) && (x < `VGA_HD + `VGA_HF + `VGA_HR));
		e.vsync = !((y >= `VGA_VD + `VGA_VF) && (y < `VGA_VD + `VGA_VF + `VGA_VR));
		e.rgb   = '0;
		if ((x < `VGA_HD) && (y < `VGA_VD))
		begin
			case (m.pattern)
				PAT_SOLID:
					e.rgb = m.color;
				PAT_BARS:
				begin
					bar     = 3'(x / 80);
					e.rgb.r = bar[2] ? 4'hf : 4'h0;
					e.rgb.g = bar[1] ? 4'hf : 4'h0;
					e.rgb.b = bar[0] ? 4'hf : 4'h0;
				end
				PAT_CHECKER:
				begin
					parity = xv[m.cell_log2] ^ yv[m.cell_log2];
					e.rgb  = parity ? ~m.color : m.color;
				end
				default:
				begin
					e.rgb.r = xv[9:6];
					e.rgb.g = yv[8:5];
					e.rgb.b = xv[9:6] ^ yv[8:5];
				end
			endcase
		end
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// a random mode with a chosen pattern
	function automatic mode_cfg_t random_mode(input pattern_e pat);
		mode_cfg_t m;
		m.pattern   = pat;
		m.color     = rgb_t'(rand_bits(12));
		m.cell_log2 = 3'(rand_bits(3));
		return m;
	endfunction

	// holds the host port until the DUT takes the write
	task automatic write_mode(input mode_cfg_t m);
		cfg_valid <= 1'b1;
		cfg_data  <= m;
		@(posedge clk);
		while (!cfg_ready)
			@(posedge clk);
		cfg_valid <= 1'b0;
	endtask

	task automatic wait_ticks(input int t);
		while (n_ticks < t)
			@(posedge clk);
	endtask

	// compare process, samples mid-cycle where every DUT output is settled
	always @(negedge clk)
	begin
		int    p;
		int    x;
		int    y;
		pins_t e;
		if (!rst)
		begin
			if (!reset_seen)
			begin
				// reset values, seen before the first tick
				check_value("reset pix_en", 32'd0, 32'(pix_en));
				check_value("reset cfg_ready", 32'd1, 32'(cfg_ready));
				check_value("reset pins", 32'(pins_t'{1'b1, 1'b1, 12'h000}),
					32'(pins_t'{hsync, vsync, rgb}));
				reset_seen = 1'b1;
			end
			else
			begin
				// the enable is high on every second clock
				check_value("pix_en toggle", 32'(!pix_en_last), 32'(pix_en));
			end
			pix_en_last = pix_en;
			// a write seen while pos is in frame f rules every frame after it
			if (cfg_valid && cfg_ready)
			begin
				accept_frame = n_ticks / FRAME_TICKS;
				for (int j = accept_frame + 1; j < 8; j++)
					mode_at[j] = cfg_data;
			end
			if (pix_en)
			begin
				if (n_ticks >= 3)
				begin
					p = n_ticks - 3;
					x = p % H_TOTAL;
					y = (p / H_TOTAL) % V_TOTAL;
					e = ref_pins(x, y, mode_at[p / FRAME_TICKS]);
					check_value($sformatf("pixel x=%0d y=%0d", x, y), 32'(e),
						32'(pins_t'{hsync, vsync, rgb}));
					if (!hsync)
						hlow++;
					if (!vsync)
						vlow++;
					if (x == H_TOTAL - 1)
					begin
						check_value($sformatf("hsync width line %0d", y), 32'(`VGA_HR), 32'(hlow));
						hlow = 0;
						if (y == V_TOTAL - 1)
						begin
							check_value("vsync width", 32'(`VGA_VR * H_TOTAL), 32'(vlow));
							vlow = 0;
						end
					end
				end
				n_ticks++;
			end
		end
	end

	initial
	begin
		lfsr         = 32'h8263_7f79;
		n_ticks      = 0;
		hlow         = 0;
		vlow         = 0;
		accept_frame = -1;
		reset_seen   = 1'b0;
		pix_en_last  = 1'b0;
		for (int j = 0; j < 8; j++)
			mode_at[j] = BOOT_MODE;
		rst       = 1'b1;
		cfg_valid = 1'b0;
		cfg_data  = '0;
		repeat (5)
			@(posedge clk);
		rst <= 1'b0;

		// first write lands in frame 1 after a random idle gap, shown from frame 2
		wait_ticks(FRAME_TICKS + 32'(rand_bits(8)) * 100);
		write_mode(random_mode(PAT_SOLID));
		@(negedge clk);
		check_value("cfg_ready while pending", 32'd0, 32'(cfg_ready));

		// a second write is held off until the frame boundary, so it shows in frame 3
		@(posedge clk);
		write_mode(random_mode(PAT_CHECKER));
		check_value("second write frame", 32'd2, 32'(accept_frame));

		// last write in frame 3, so frame 4 shows the gradient
		wait_ticks(3 * FRAME_TICKS + 32'(rand_bits(8)) * 50);
		repeat (32'(rand_bits(4)))
			@(posedge clk);
		write_mode(random_mode(PAT_GRADIENT));

		wait_ticks(END_TICKS);
		@(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

	// watchdog sized for five frames of two clocks per pixel plus reset
	initial
	begin
		#(WATCHDOG);
		$display("watchdog expired before five frames were checked");
		$display("Finished with errors");
		$fatal(1);
	end

endmodule

/* sim.f */
+incdir+hdl
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/mode_regs.sv
hdl/pattern_gen.sv
hdl/vga_out.sv
hdl/vga_top.sv
sim/vga_tb.sv
